//--- all.f
source/vec_pkg.sv
source/vec_lane_alu.sv
source/vreg_file.sv
source/vec_sequencer.sv
source/vec_top.sv
tests/vec_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vector slice testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module vec_top_tb -f all.f -o vec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/vec_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
exit 1

//--- tests/vec_top_tb.sv
/*
 * Vector slice testbench
 * table of host writes, commands and read checks against a byte model
 */

`timescale 1ns/1ns
`default_nettype none

module vec_top_tb;
  import vec_pkg::*;

  localparam int NUM_REGS       = 32;
  localparam int CLK_PERIOD     = 100;
  localparam int CYCLES_PER_ROW = 200;

  typedef enum logic [1:0] {
    ROW_HWR,
    ROW_CMD,
    ROW_CHK
  } row_kind_t;

  // data is the write value, or the expected value when use_model is clear
  typedef struct packed {
    row_kind_t   kind;
    logic [4:0]  vreg;
    offset_t     offset;
    sew_t        sew;
    logic [31:0] data;
    logic        use_model;
    vcmd_t       cmd;
    logic        chain;
  } row_t;

  logic        CLK;
  logic        nRST;
  logic        cmd_valid;
  vcmd_t       cmd;
  logic        cmd_ready;
  logic        host_wr_valid;
  host_wr_t    host_wr;
  logic        host_wr_ready;
  logic [4:0]  host_rd_reg;
  offset_t     host_rd_offset;
  sew_t        host_rd_sew;
  logic [31:0] host_rd_data;
  logic        done;

  logic [7:0]  ref_mem [NUM_REGS*16];
  row_t        rows [$];
  row_t        cur;
  int          errors;
  logic        next_taken;
  logic        table_ready;
  logic        fire;

  vec_top #(
    .NUM_REGS (NUM_REGS)
  ) u_vec_top (
    .CLK            (CLK),
    .nRST           (nRST),
    .cmd_valid      (cmd_valid),
    .cmd            (cmd),
    .cmd_ready      (cmd_ready),
    .host_wr_valid  (host_wr_valid),
    .host_wr        (host_wr),
    .host_wr_ready  (host_wr_ready),
    .host_rd_reg    (host_rd_reg),
    .host_rd_offset (host_rd_offset),
    .host_rd_sew    (host_rd_sew),
    .host_rd_data   (host_rd_data),
    .done           (done)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // byte address of an element with 1 << sew bytes and 16 bytes per register
  function automatic int elem_addr(logic [4:0] vreg, int off, sew_t s);
    int esz;
    esz = 1 << int'(s);
    return (int'(vreg) + off / (16 / esz)) * 16 + (off % (16 / esz)) * esz;
  endfunction

  function automatic logic [31:0] mem_read(logic [4:0] vreg, int off, sew_t s);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < (1 << int'(s)); k++) begin
      v[8*k +: 8] = ref_mem[elem_addr(vreg, off, s) + k];
    end
    return v;
  endfunction

  // only the element's own bytes change, so wider results are cut here
  task automatic mem_write(logic [4:0] vreg, int off, sew_t s, logic [31:0] v);
    for (int k = 0; k < (1 << int'(s)); k++) begin
      ref_mem[elem_addr(vreg, off, s) + k] = v[8*k +: 8];
    end
  endtask

  // vd = vs2 op vs1 on body elements whose v0 bit allows it
  task automatic apply_vop(vcmd_t c);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    for (int i = 0; i < int'(c.vl); i++) begin
      a = mem_read(c.vs1, i, c.sew);
      b = mem_read(c.vs2, i, c.sew);
      case (c.op)
        VADD:    r = b + a;
        VSUB:    r = b - a;
        VAND:    r = b & a;
        VOR:     r = b | a;
        VXOR:    r = b ^ a;
        default: r = a;
      endcase
      if (!c.masked || (((ref_mem[i / 8] >> (i % 8)) & 8'h01) != 8'h00)) begin
        mem_write(c.vd, i, c.sew, r);
      end
    end
  endtask

  task automatic check_value(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic push_row(row_kind_t kind, logic [4:0] vreg, int off, sew_t s,
                          logic [31:0] data, logic use_model);
    row_t r;
    r = '0;
    r.kind      = kind;
    r.vreg      = vreg;
    r.offset    = offset_t'(off);
    r.sew       = s;
    r.data      = data;
    r.use_model = use_model;
    rows.push_back(r);
  endtask

  task automatic push_cmd(vop_t op, logic [4:0] vd, logic [4:0] vs1, logic [4:0] vs2,
                          sew_t s, int vl, logic masked, logic chain);
    row_t r;
    r = '0;
    r.kind  = ROW_CMD;
    r.cmd   = '{op: op, vd: vd, vs1: vs1, vs2: vs2, sew: s, vl: vlen_t'(vl),
                masked: masked};
    r.chain = chain;
    rows.push_back(r);
  endtask

  // count model checks from offset 0, one past vl covers the tail
  task automatic push_span(logic [4:0] vreg, sew_t s, int count);
    for (int e = 0; e < count; e++) begin
      push_row(ROW_CHK, vreg, e, s, 32'h0, 1'b1);
    end
  endtask

  task automatic fill_group(logic [4:0] vreg, sew_t s, int count);
    for (int e = 0; e < count; e++) begin
      push_row(ROW_HWR, vreg, e, s, $urandom, 1'b0);
    end
  endtask

  task automatic build_table();
    logic [31:0] d8;
    logic [31:0] d16;
    logic [31:0] d32;
    d8  = $urandom;
    d16 = $urandom;
    d32 = $urandom;
    // single elements at each width with zero neighbours
    push_row(ROW_HWR, 5'd3, 5, SEW8, d8, 1'b0);
    push_row(ROW_CHK, 5'd3, 5, SEW8, {24'h0, d8[7:0]}, 1'b0);
    push_row(ROW_CHK, 5'd3, 4, SEW8, 32'h0, 1'b0);
    push_row(ROW_CHK, 5'd3, 6, SEW8, 32'h0, 1'b0);
    push_row(ROW_HWR, 5'd4, 3, SEW16, d16, 1'b0);
    push_row(ROW_CHK, 5'd4, 3, SEW16, {16'h0, d16[15:0]}, 1'b0);
    push_row(ROW_CHK, 5'd4, 2, SEW16, 32'h0, 1'b0);
    push_row(ROW_CHK, 5'd4, 5, SEW8, 32'h0, 1'b0);
    push_row(ROW_HWR, 5'd5, 2, SEW32, d32, 1'b0);
    push_row(ROW_CHK, 5'd5, 2, SEW32, d32, 1'b0);
    push_row(ROW_CHK, 5'd5, 3, SEW32, 32'h0, 1'b0);
    push_row(ROW_CHK, 5'd5, 8, SEW8, {24'h0, d32[7:0]}, 1'b0);
    // all six opcodes on eight 16-bit elements into v10..v15
    fill_group(5'd8, SEW16, 8);
    fill_group(5'd9, SEW16, 8);
    for (int k = 0; k < 6; k++) begin
      push_cmd(vop_t'(3'(k)), 5'(10 + k), 5'd8, 5'd9, SEW16, 8, 1'b0, 1'b0);
      push_span(5'(10 + k), SEW16, 9);
    end
    fill_group(5'd16, SEW8, 8);
    fill_group(5'd17, SEW8, 8);
    push_cmd(VADD, 5'd18, 5'd16, 5'd17, SEW8, 8, 1'b0, 1'b0);
    push_span(5'd18, SEW8, 9);
    // group of three registers at SEW32
    fill_group(5'd20, SEW32, 10);
    fill_group(5'd23, SEW32, 10);
    push_cmd(VADD, 5'd26, 5'd20, 5'd23, SEW32, 10, 1'b0, 1'b0);
    push_span(5'd26, SEW32, 11);
    // odd vl leaves element 7 alone and vl 0 writes nothing
    push_row(ROW_HWR, 5'd19, 7, SEW8, $urandom, 1'b0);
    push_cmd(VXOR, 5'd19, 5'd16, 5'd17, SEW8, 7, 1'b0, 1'b0);
    push_span(5'd19, SEW8, 8);
    push_cmd(VADD, 5'd19, 5'd16, 5'd17, SEW8, 0, 1'b0, 1'b0);
    push_span(5'd19, SEW8, 1);
    // v0 = 1010_0110 then a masked subtract over v10
    push_row(ROW_HWR, 5'd0, 0, SEW8, 32'h0000_00a6, 1'b0);
    push_cmd(VSUB, 5'd10, 5'd8, 5'd9, SEW16, 8, 1'b1, 1'b0);
    push_span(5'd10, SEW16, 9);
    // second command offered while the first one runs
    push_cmd(VOR, 5'd30, 5'd8, 5'd9, SEW16, 8, 1'b0, 1'b1);
    push_cmd(VAND, 5'd31, 5'd8, 5'd9, SEW16, 5, 1'b1, 1'b0);
    push_span(5'd30, SEW16, 8);
    push_span(5'd31, SEW16, 6);
  endtask

  // ceil(vl/2) steps with one step for vl 0
  task automatic wait_done(vcmd_t c, logic chained);
    int steps;
    int want;
    steps = 0;
    want  = (c.vl == 8'd0) ? 1 : (int'(c.vl) + 1) / 2;
    @(negedge CLK);
    while (!done) begin
      steps++;
      check_value(32'(cmd_ready), 32'd0, "cmd_ready while busy");
      check_value(32'(host_wr_ready), 32'd0, "host_wr_ready while busy");
      @(negedge CLK);
    end
    check_value(32'(steps), 32'(want), "step count");
    check_value(32'(cmd_ready), 32'd1, "cmd_ready in the done cycle");
    next_taken = chained && cmd_ready;
    @(posedge CLK);
    #1;
    if (next_taken) begin
      cmd_valid = 1'b0;
    end
  endtask

  initial begin
    CLK            = 1'b0;
    nRST           = 1'b0;
    cmd_valid      = 1'b0;
    cmd            = '0;
    host_wr_valid  = 1'b0;
    host_wr        = '0;
    host_rd_reg    = '0;
    host_rd_offset = '0;
    host_rd_sew    = SEW8;
    errors         = 0;
    next_taken     = 1'b0;
    table_ready    = 1'b0;
    for (int i = 0; i < NUM_REGS*16; i++) begin
      ref_mem[i] = 8'h00;
    end
    void'($urandom(32'hef56));
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    check_value(32'(cmd_ready), 32'd1, "cmd_ready after reset");
    check_value(32'(host_wr_ready), 32'd1, "host_wr_ready after reset");
    check_value(32'(done), 32'd0, "done after reset");
    @(posedge CLK);
    #1;
    // whole file reads back zero after reset
    for (int r = 0; r < NUM_REGS; r++) begin
      for (int e = 0; e < 4; e++) begin
        host_rd_reg    = 5'(r);
        host_rd_sew    = SEW32;
        host_rd_offset = offset_t'(e);
        @(negedge CLK);
        check_value(host_rd_data, 32'h0, $sformatf("v%0d word %0d after reset", r, e));
        @(posedge CLK);
        #1;
      end
    end
    for (int i = 0; i < rows.size(); i++) begin
      cur = rows[i];
      case (cur.kind)
        ROW_HWR: begin
          host_wr       = '{vreg: cur.vreg, offset: cur.offset, sew: cur.sew,
                            data: cur.data};
          host_wr_valid = 1'b1;
          fire          = 1'b0;
          while (!fire) begin
            @(negedge CLK);
            fire = host_wr_ready;
            @(posedge CLK);
            #1;
          end
          host_wr_valid = 1'b0;
          mem_write(cur.vreg, int'(cur.offset), cur.sew, cur.data);
        end
        ROW_CMD: begin
          // a chained command was already taken in the previous done cycle
          if (!next_taken) begin
            cmd       = cur.cmd;
            cmd_valid = 1'b1;
            fire      = 1'b0;
            while (!fire) begin
              @(negedge CLK);
              fire = cmd_ready;
              @(posedge CLK);
              #1;
            end
            cmd_valid = 1'b0;
          end
          next_taken = 1'b0;
          if (cur.chain && i + 1 < rows.size()) begin
            cmd       = rows[i + 1].cmd;
            cmd_valid = 1'b1;
          end
          apply_vop(cur.cmd);
          wait_done(cur.cmd, cur.chain);
        end
        default: begin
          host_rd_reg    = cur.vreg;
          host_rd_offset = cur.offset;
          host_rd_sew    = cur.sew;
          @(negedge CLK);
          check_value(host_rd_data,
                      cur.use_model ? mem_read(cur.vreg, int'(cur.offset), cur.sew)
                                    : cur.data,
                      $sformatf("v%0d element %0d at %0d bits", cur.vreg, cur.offset,
                                8 << int'(cur.sew)));
          @(posedge CLK);
          #1;
        end
      endcase
    end
    $display("errors: %0d after %0d table rows", errors, rows.size());
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(rows.size() + 2) * CYCLES_PER_ROW * CLK_PERIOD;
    #(limit_ns);
    $display("watchdog expired after %0d ns, the run did not finish", limit_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/vec_top.sv
/*
 * Two-lane vector slice
 * sequencer, register file and two lane ALUs
 */

`timescale 1ns/1ns
`default_nettype none

module vec_top #(
  parameter int NUM_REGS = 32
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              cmd_valid,
  input  vec_pkg::vcmd_t    cmd,
  output logic              cmd_ready,
  input  logic              host_wr_valid,
  input  vec_pkg::host_wr_t host_wr,
  output logic              host_wr_ready,
  input  logic [4:0]        host_rd_reg,
  input  vec_pkg::offset_t  host_rd_offset,
  input  vec_pkg::sew_t     host_rd_sew,
  output logic [31:0]       host_rd_data,
  output logic              done
);
  import vec_pkg::*;

  rf_req_t          rf_req;
  vop_t             op;
  logic             masked;
  logic             step_active;
  logic             host_sel;
  lane_wr_t [1:0]   lane_wr;
  logic [1:0][31:0] vs1_data;
  logic [1:0][31:0] vs2_data;
  logic [1:0]       mask;

  vec_sequencer u_seq (
    .CLK           (CLK),
    .nRST          (nRST),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .cmd_ready     (cmd_ready),
    .host_wr_valid (host_wr_valid),
    .host_wr       (host_wr),
    .host_wr_ready (host_wr_ready),
    .rf_req        (rf_req),
    .op            (op),
    .masked        (masked),
    .step_active   (step_active),
    .host_sel      (host_sel),
    .done          (done)
  );

  // host element enters through the file's lane 0 write source
  vreg_file #(
    .NUM_REGS (NUM_REGS)
  ) u_rf (
    .CLK            (CLK),
    .nRST           (nRST),
    .rf_req         (rf_req),
    .lane_wr        (lane_wr),
    .host_sel       (host_sel),
    .host_wdata     (host_wr.data),
    .vs1_data       (vs1_data),
    .vs2_data       (vs2_data),
    .mask           (mask),
    .host_rd_reg    (host_rd_reg),
    .host_rd_offset (host_rd_offset),
    .host_rd_sew    (host_rd_sew),
    .host_rd_data   (host_rd_data)
  );

  vec_lane_alu u_lane0 (
    .op       (op),
    .sew      (rf_req.sew),
    .a        (vs1_data[0]),
    .b        (vs2_data[0]),
    .mask_bit (mask[0]),
    .masked   (masked),
    .active   (step_active),
    .wr       (lane_wr[0])
  );

  vec_lane_alu u_lane1 (
    .op       (op),
    .sew      (rf_req.sew),
    .a        (vs1_data[1]),
    .b        (vs2_data[1]),
    .mask_bit (mask[1]),
    .masked   (masked),
    .active   (step_active),
    .wr       (lane_wr[1])
  );

endmodule

`default_nettype wire

//--- source/vec_sequencer.sv
/*
 * Vector sequencer
 * accepts one command, walks element offsets two per cycle up to vl,
 * and turns idle-time host writes into single-element file requests
 */

`timescale 1ns/1ns
`default_nettype none

module vec_sequencer (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              cmd_valid,
  input  vec_pkg::vcmd_t    cmd,
  output logic              cmd_ready,
  input  logic              host_wr_valid,
  input  vec_pkg::host_wr_t host_wr,
  output logic              host_wr_ready,
  output vec_pkg::rf_req_t  rf_req,
  output vec_pkg::vop_t     op,
  output logic              masked,
  output logic              step_active,
  output logic              host_sel,
  output logic              done
);
  import vec_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } state_t;

  state_t  state;
  state_t  next_state;
  vcmd_t   cmd_q;
  offset_t offset_q;
  vlen_t   next_offset;
  logic    last_step;
  logic    cmd_take;
  logic    host_take;

  assign cmd_ready = (state == IDLE);
  // a command offered in the same cycle wins over the host
  assign host_wr_ready = (state == IDLE) && !cmd_valid;

  assign cmd_take  = cmd_valid && cmd_ready;
  assign host_take = host_wr_valid && host_wr_ready;

  // two elements per step
  assign next_offset = vlen_t'(offset_q) + 8'd2;
  assign last_step   = (next_offset >= cmd_q.vl);

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (cmd_take) begin
          next_state = RUN;
        end
      end
      RUN: begin
        if (last_step) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      cmd_q    <= '0;
      offset_q <= '0;
      done     <= 1'b0;
    end else begin
      state <= next_state;
      // pulse in the cycle right after the final step
      done  <= (state == RUN) && last_step;
      if (cmd_take) begin
        cmd_q    <= cmd;
        offset_q <= '0;
      end else if (state == RUN) begin
        offset_q <= offset_q + 7'd2;
      end
    end
  end

  always_comb begin
    rf_req.vd     = cmd_q.vd;
    rf_req.vs1    = cmd_q.vs1;
    rf_req.vs2    = cmd_q.vs2;
    rf_req.offset = offset_q;
    rf_req.sew    = cmd_q.sew;
    // nothing may land while idle
    rf_req.vl     = (state == RUN) ? cmd_q.vl : 8'd0;
    host_sel      = 1'b0;
    if (host_take) begin
      rf_req.vd     = host_wr.vreg;
      rf_req.offset = host_wr.offset;
      rf_req.sew    = host_wr.sew;
      // vl just past the element so the tail check lets it through
      rf_req.vl     = vlen_t'(host_wr.offset) + 8'd1;
      host_sel      = 1'b1;
    end
  end

  assign op          = cmd_q.op;
  assign masked      = cmd_q.masked;
  assign step_active = (state == RUN);

endmodule

`default_nettype wire

//--- source/vreg_file.sv
/*
 * Vector register file
 * two lane write ports, two lane reads for vs1 and vs2, v0 mask bits
 * and a single-element host read port, all mapped by element width
 */

`timescale 1ns/1ns
`default_nettype none

module vreg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  vec_pkg::rf_req_t        rf_req,
  input  vec_pkg::lane_wr_t [1:0] lane_wr,
  input  logic                    host_sel,
  input  logic [31:0]             host_wdata,
  output logic [1:0][31:0]        vs1_data,
  output logic [1:0][31:0]        vs2_data,
  output logic [1:0]              mask,
  input  logic [4:0]              host_rd_reg,
  input  vec_pkg::offset_t        host_rd_offset,
  input  vec_pkg::sew_t           host_rd_sew,
  output logic [31:0]             host_rd_data
);
  import vec_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  vreg_t [NUM_REGS-1:0]    regs;
  vreg_t [NUM_REGS-1:0]    next_regs;
  logic [127:0]            v0_bits;

  offset_t [1:0]           lane_off;
  logic [1:0]              lane_in_vl;
  logic [1:0][3:0]         lane_pos;
  logic [1:0][IDX_W-1:0]   wr_idx;
  logic [1:0][IDX_W-1:0]   vs1_idx;
  logic [1:0][IDX_W-1:0]   vs2_idx;
  logic [1:0]              wr_en;
  logic [1:0][31:0]        wr_data;
  logic [IDX_W-1:0]        host_idx;

  // base register plus how many whole registers the offset has passed
  function automatic logic [IDX_W-1:0] reg_index(input logic [4:0] base,
                                                 input offset_t off,
                                                 input sew_t sew);
    logic [4:0] grp;
    case (sew)
      SEW32:   grp = off[6:2];
      SEW16:   grp = {1'b0, off[6:3]};
      default: grp = {2'b00, off[6:4]};
    endcase
    return IDX_W'({1'b0, base} + {1'b0, grp});
  endfunction

  // first byte of the element inside its register
  function automatic logic [3:0] byte_pos(input offset_t off, input sew_t sew);
    case (sew)
      SEW32:   return {off[1:0], 2'b00};
      SEW16:   return {off[2:0], 1'b0};
      default: return off[3:0];
    endcase
  endfunction

  function automatic logic [31:0] read_elem(input vreg_t r,
                                            input logic [3:0] pos,
                                            input sew_t sew);
    case (sew)
      SEW32:   return r[pos +: 4];
      SEW16:   return {16'h0, r[pos +: 2]};
      default: return {24'h0, r[pos]};
    endcase
  endfunction

  assign lane_off[0] = rf_req.offset;
  assign lane_off[1] = rf_req.offset + 7'd1;

  // tail check done at 8 bits so vl = 128 covers offset 127
  assign lane_in_vl[0] = vlen_t'(rf_req.offset) < rf_req.vl;
  assign lane_in_vl[1] = (vlen_t'(rf_req.offset) + 8'd1) < rf_req.vl;

  // host write borrows lane 0, lane 1 stays quiet
  assign wr_en[0]   = host_sel ? 1'b1 : lane_wr[0].wen;
  assign wr_data[0] = host_sel ? host_wdata : lane_wr[0].data;
  assign wr_en[1]   = !host_sel && lane_wr[1].wen;
  assign wr_data[1] = lane_wr[1].data;

  assign v0_bits = regs[0];

  for (genvar l = 0; l < 2; l++) begin : g_lane
    assign lane_pos[l] = byte_pos(lane_off[l], rf_req.sew);
    assign wr_idx[l]   = reg_index(rf_req.vd, lane_off[l], rf_req.sew);
    assign vs1_idx[l]  = reg_index(rf_req.vs1, lane_off[l], rf_req.sew);
    assign vs2_idx[l]  = reg_index(rf_req.vs2, lane_off[l], rf_req.sew);
    assign vs1_data[l] = read_elem(regs[vs1_idx[l]], lane_pos[l], rf_req.sew);
    assign vs2_data[l] = read_elem(regs[vs2_idx[l]], lane_pos[l], rf_req.sew);
    // one mask bit per element, straight from v0
    assign mask[l]     = v0_bits[lane_off[l]];
  end

  assign host_idx     = reg_index(host_rd_reg, host_rd_offset, host_rd_sew);
  assign host_rd_data = read_elem(regs[host_idx],
                                  byte_pos(host_rd_offset, host_rd_sew),
                                  host_rd_sew);

  always_comb begin
    next_regs = regs;
    for (int l = 0; l < 2; l++) begin
      if (wr_en[l] && lane_in_vl[l]) begin
        case (rf_req.sew)
          SEW32:   next_regs[wr_idx[l]][lane_pos[l] +: 4] = wr_data[l];
          SEW16:   next_regs[wr_idx[l]][lane_pos[l] +: 2] = wr_data[l][15:0];
          default: next_regs[wr_idx[l]][lane_pos[l]]      = wr_data[l][7:0];
        endcase
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '0;
    end else begin
      regs <= next_regs;
    end
  end

endmodule

`default_nettype wire

//--- source/vec_lane_alu.sv
/*
 * Lane ALU
 * one element operation per cycle, result cut to the element width,
 * write enable dropped for masked-off elements
 */

`timescale 1ns/1ns
`default_nettype none

module vec_lane_alu (
  input  vec_pkg::vop_t     op,
  input  vec_pkg::sew_t     sew,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic              mask_bit,
  input  logic              masked,
  input  logic              active,
  output vec_pkg::lane_wr_t wr
);
  import vec_pkg::*;

  logic [31:0] result;
  logic [31:0] result_trunc;

  // a is the vs1 element, b the vs2 element
  always_comb begin
    case (op)
      VADD:    result = b + a;
      // vs2 minus vs1, as in vsub.vv
      VSUB:    result = b - a;
      VAND:    result = b & a;
      VOR:     result = b | a;
      VXOR:    result = b ^ a;
      VMV:     result = a;
      default: result = '0;
    endcase
  end

  always_comb begin
    case (sew)
      SEW8:    result_trunc = {24'h0, result[7:0]};
      SEW16:   result_trunc = {16'h0, result[15:0]};
      default: result_trunc = result;
    endcase
  end

  // masked-off elements keep their old value
  assign wr.wen  = active && !(masked && !mask_bit);
  assign wr.data = result_trunc;

endmodule

`default_nettype wire

//--- source/vec_pkg.sv
/*
 * Vector slice shared types
 * element widths, opcodes, command and register-file request structs
 * used by the sequencer, the register file and the lane ALUs
 */

`default_nettype none

package vec_pkg;

  // 128-bit registers split into bytes
  localparam int VREG_BYTES = 16;
  localparam int REG_ADDR_W = 5;
  localparam int ELEM_W     = 32;

  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32
  } sew_t;

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMV
  } vop_t;

  // element index inside a register group
  typedef logic [6:0] offset_t;
  // 0 to 128 elements
  typedef logic [7:0] vlen_t;

  typedef logic [VREG_BYTES-1:0][7:0] vreg_t;

  typedef struct packed {
    vop_t                  op;
    logic [REG_ADDR_W-1:0] vd;
    logic [REG_ADDR_W-1:0] vs1;
    logic [REG_ADDR_W-1:0] vs2;
    sew_t                  sew;
    vlen_t                 vl;
    logic                  masked;
  } vcmd_t;

  typedef struct packed {
    logic              wen;
    logic [ELEM_W-1:0] data;
  } lane_wr_t;

  // one step of register-file access with lane 1 at offset + 1
  typedef struct packed {
    logic [REG_ADDR_W-1:0] vd;
    logic [REG_ADDR_W-1:0] vs1;
    logic [REG_ADDR_W-1:0] vs2;
    offset_t               offset;
    sew_t                  sew;
    vlen_t                 vl;
  } rf_req_t;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] vreg;
    offset_t               offset;
    sew_t                  sew;
    logic [ELEM_W-1:0]     data;
  } host_wr_t;

endpackage

`default_nettype wire
